// ==== apb_host_regs.sv ====
`timescale 1ns/1ps
`include "fcore_io_params.svh"

module apb_host_regs (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [3:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       start_req,
    output fcore_io_pkg::operand_sel_t operand_sel,
    input  logic                       busy,
    input  logic                       core_done,
    input  logic [31:0]                result
);
    import fcore_io_pkg::*;

    logic        access;
    logic        wr_access;
    logic        mapped;
    logic        done_q;
    logic [31:0] result_q;

    // Every access finishes in its access phase
    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr_access = access && pwrite;

    // Read mux, and whether the offset belongs to a register at all
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            `FCORE_REG_CTRL: prdata = '0;
            `FCORE_REG_STATUS: prdata = {30'd0, done_q, busy};
            `FCORE_REG_OPERAND: prdata = 32'(operand_sel);
            `FCORE_REG_RESULT: prdata = result_q;
            default: mapped = 1'b0;
        endcase
    end

    assign pslverr = access && !mapped;

    // A start while the core is busy is dropped here
    assign start_req = wr_access && (paddr == `FCORE_REG_CTRL) && pwdata[0] && !busy;

    always_ff @(posedge clock) begin
        if (reset) begin
            operand_sel <= '0;
            done_q <= 1'b0;
            result_q <= '0;
        end else begin
            if (wr_access && paddr == `FCORE_REG_OPERAND) begin
                operand_sel <= operand_sel_t'(pwdata[$bits(operand_sel_t)-1:0]);
            end
            // Done stays set until the next start clears it
            if (start_req) begin
                done_q <= 1'b0;
            end else if (core_done) begin
                done_q <= 1'b1;
            end
            if (core_done) begin
                result_q <= result;
            end
        end
    end

    // An accepted start must show up as busy on the next cycle
    assert property (@(posedge clock) disable iff (reset) start_req |=> busy);

endmodule

// ==== common_io_memory.sv ====
`timescale 1ns/1ps
`include "fcore_io_params.svh"

module common_io_memory (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    core_start,
    input  logic                    core_done,
    input  logic                    wr_valid,
    input  fcore_io_pkg::io_write_t wr_data,
    output logic                    wr_ready,
    input  fcore_io_pkg::io_addr_t  read_addr_a,
    input  fcore_io_pkg::io_addr_t  read_addr_b,
    input  fcore_io_pkg::io_addr_t  read_addr_c,
    output logic [31:0]             read_data_a,
    output logic [31:0]             read_data_b,
    output logic [31:0]             read_data_c
);
    import fcore_io_pkg::*;

    localparam int N_IO = `FCORE_N_IO;

    logic [`FCORE_DATA_W-1:0] mem [N_IO];
    io_state_e                state;

    // Writes are refused from the start pulse itself, so the word the core
    // fetches in its first cycle cannot change under it
    assign wr_ready = (state == dma_enabled) && !core_start;

    // Stays in core_running up to and including the done pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dma_enabled;
        end else begin
            case (state)
                dma_enabled: begin
                    if (core_start) begin
                        state <= core_running;
                    end
                end
                core_running: begin
                    if (core_done) begin
                        state <= dma_enabled;
                    end
                end
                default: begin
                    state <= dma_enabled;
                end
            endcase
        end
    end

    // The memory is cleared on reset so a run right after it reads zeros
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N_IO; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_valid && wr_ready) begin
            mem[wr_data.dest] <= wr_data.data;
        end
    end

    // Three registered read ports, data one cycle after the address
    always_ff @(posedge clock) begin
        read_data_a <= mem[read_addr_a];
        read_data_b <= mem[read_addr_b];
        read_data_c <= mem[read_addr_c];
    end

    // No stream word may land anywhere in the window from start to done
    assert property (@(posedge clock) disable iff (reset)
        core_start |-> (!(wr_valid && wr_ready)) throughout (core_done [->1]));

    // The memory and the core must agree on when a run is in progress
    assert property (@(posedge clock) disable iff (reset)
        core_done |-> state == core_running);

endmodule

// ==== fcore_io.f ====
+incdir+.
fcore_io_pkg.sv
io_stream_fifo.sv
io_write_arbiter.sv
common_io_memory.sv
io_compute_core.sv
apb_host_regs.sv
fcore_io_top.sv
fcore_io_tb.sv

// ==== fcore_io_params.svh ====
`ifndef FCORE_IO_PARAMS_SVH
`define FCORE_IO_PARAMS_SVH

// Number of 32-bit words in the shared I/O memory
`define FCORE_N_IO 32

// Index width into the memory follows from its size
`define FCORE_ADDR_W $clog2(`FCORE_N_IO)

// Width of one memory word and of the stream payload data
`define FCORE_DATA_W 32

// Words held by each DMA channel buffer
`define FCORE_FIFO_DEPTH 4

// APB byte offsets of the host registers
`define FCORE_REG_CTRL 4'h0
`define FCORE_REG_STATUS 4'h4
`define FCORE_REG_OPERAND 4'h8
`define FCORE_REG_RESULT 4'hC

`endif

// ==== fcore_io_pkg.sv ====
`include "fcore_io_params.svh"

package fcore_io_pkg;

    // Index of one word in the shared I/O memory
    typedef logic [`FCORE_ADDR_W-1:0] io_addr_t;

    // Stream payload, the word and where it goes in the memory
    typedef struct packed {
        io_addr_t dest;
        logic [`FCORE_DATA_W-1:0] data;
    } io_write_t;

    // Operations the compute core can apply to its three operands
    typedef enum logic [1:0] {
        op_add3 = 2'd0,
        op_mac = 2'd1,
        op_sub = 2'd2,
        op_max3 = 2'd3
    } core_op_e;

    // Host selection of the opcode and of the three operand words
    typedef struct packed {
        core_op_e opcode;
        io_addr_t addr_a;
        io_addr_t addr_b;
        io_addr_t addr_c;
    } operand_sel_t;

    // The memory either takes stream writes or holds still for the core
    typedef enum logic {
        dma_enabled = 1'b0,
        core_running = 1'b1
    } io_state_e;

    typedef enum logic [1:0] {
        core_idle = 2'd0,
        core_fetch = 2'd1,
        core_exec = 2'd2,
        core_store = 2'd3
    } core_state_e;

endpackage

// ==== fcore_io_tb.sv ====
`timescale 1ns/1ps
`include "fcore_io_params.svh"

module fcore_io_tb;
    import fcore_io_pkg::*;

    localparam int N_STIM = 6;
    localparam int WAIT_LIMIT = 60;
    // The table never writes this word, so it reads as zero for the whole run
    localparam io_addr_t ZERO_ADDR = 5'd31;

    // One table row: two words per channel, the core run, and whether the
    // words are sent while the core is busy
    typedef struct packed {
        io_addr_t [1:0] dest0;
        io_addr_t [1:0] dest1;
        operand_sel_t   sel;
        logic           inject;
    } stim_entry_t;

    logic        clock;
    logic        reset;
    logic        dma0_valid;
    io_write_t   dma0_data;
    logic        dma0_ready;
    logic        dma1_valid;
    io_write_t   dma1_data;
    logic        dma1_ready;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference copy of the shared memory, updated once words have drained
    logic [31:0]     model [`FCORE_N_IO];
    stim_entry_t     stim [N_STIM];
    stim_entry_t     entry;
    io_write_t [1:0] words0;
    io_write_t [1:0] words1;
    operand_sel_t    sel;
    logic [31:0]     expected;
    logic [31:0]     got;
    logic [31:0]     rdata;
    logic            err;
    int              tests_run;
    int              tests_failed;
    int              test_errors;

    fcore_io_top fcore_io_top_i (
        .clock(clock), .reset(reset),
        .dma0_valid(dma0_valid), .dma0_data(dma0_data), .dma0_ready(dma0_ready),
        .dma1_valid(dma1_valid), .dma1_data(dma1_data), .dma1_ready(dma1_ready),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #4 clock = ~clock;

    // Result of one opcode as the host expects it, taken from the model words
    function automatic logic [31:0] expected_result(input operand_sel_t s);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [63:0] product;
        logic [31:0] biggest;
        a = model[s.addr_a];
        b = model[s.addr_b];
        c = model[s.addr_c];
        product = 64'(a) * 64'(b);
        biggest = a;
        if (b > biggest) biggest = b;
        if (c > biggest) biggest = c;
        case (s.opcode)
            op_add3: return a + b + c;
            op_mac: return product[31:0] + c;
            op_sub: return a - b - c;
            default: return biggest;
        endcase
    endfunction

    // Setup phase, then access phase held until pready, sampled mid-cycle
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] data, output logic slverr);
        int waited;
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        waited = 0;
        while (!pready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!pready) begin
            $display("APB access to offset %h never completed", addr);
            test_errors++;
        end
        data = prdata;
        slverr = pslverr;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    // Returns on the edge that starts the core
    task automatic start_core(input operand_sel_t s);
        logic [31:0] d;
        logic e;
        apb_access(1'b1, `FCORE_REG_OPERAND, 32'(s), d, e);
        apb_access(1'b1, `FCORE_REG_CTRL, 32'h1, d, e);
    endtask

    // Polls the sticky done bit, then reads the result
    task automatic finish_core(output logic [31:0] res);
        logic [31:0] status;
        logic e;
        int polls;
        polls = 0;
        apb_access(1'b0, `FCORE_REG_STATUS, '0, status, e);
        while (!status[1] && polls < WAIT_LIMIT) begin
            apb_access(1'b0, `FCORE_REG_STATUS, '0, status, e);
            polls++;
        end
        if (!status[1]) begin
            $display("core never reported done in STATUS");
            test_errors++;
        end
        apb_access(1'b0, `FCORE_REG_RESULT, '0, res, e);
    endtask

    task automatic dma_send(input int ch, input io_write_t word, output time accepted);
        int waited;
        logic ready;
        @(posedge clock);
        if (ch == 0) begin
            dma0_valid <= 1'b1;
            dma0_data <= word;
        end else begin
            dma1_valid <= 1'b1;
            dma1_data <= word;
        end
        waited = 0;
        @(negedge clock);
        ready = (ch == 0) ? dma0_ready : dma1_ready;
        while (!ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            ready = (ch == 0) ? dma0_ready : dma1_ready;
            waited++;
        end
        if (!ready) begin
            $display("DMA channel %0d never accepted a word", ch);
            test_errors++;
        end
        @(posedge clock);
        accepted = $time;
        if (ch == 0) begin
            dma0_valid <= 1'b0;
        end else begin
            dma1_valid <= 1'b0;
        end
    endtask

    // Both channels stream their two words at the same time
    task automatic send_both(input io_write_t [1:0] w0, input io_write_t [1:0] w1);
        time t0;
        time t1;
        fork
            begin
                for (int k = 0; k < 2; k++) dma_send(0, w0[k], t0);
            end
            begin
                for (int k = 0; k < 2; k++) dma_send(1, w1[k], t1);
            end
        join
    endtask

    // With both FIFOs empty the arbiter shows no valid word to the memory
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clock);
        while (fcore_io_top_i.mem_valid && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (fcore_io_top_i.mem_valid) begin
            $display("DMA words did not drain into the memory");
            test_errors++;
        end
    endtask

    task automatic set_entry(input int idx, input io_addr_t d00, input io_addr_t d01,
                             input io_addr_t d10, input io_addr_t d11, input core_op_e op,
                             input io_addr_t a, input io_addr_t b, input io_addr_t c,
                             input logic inj);
        stim[idx].dest0[0] = d00;
        stim[idx].dest0[1] = d01;
        stim[idx].dest1[0] = d10;
        stim[idx].dest1[1] = d11;
        stim[idx].sel.opcode = op;
        stim[idx].sel.addr_a = a;
        stim[idx].sel.addr_b = b;
        stim[idx].sel.addr_c = c;
        stim[idx].inject = inj;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end else begin
            $display("%s: ok", name);
        end
        test_errors = 0;
    endtask

    // A lone word from first_ch hands priority to the other channel, so when
    // both then hit the same dest together, first_ch writes last
    task automatic check_round_robin(input int first_ch);
        io_write_t lone;
        io_write_t w0;
        io_write_t w1;
        time t0;
        time t1;
        operand_sel_t s;
        logic [31:0] res;
        lone.dest = 5'd24;
        lone.data = $urandom();
        dma_send(first_ch, lone, t0);
        wait_drain();
        model[24] = lone.data;
        w0.dest = 5'd25;
        w0.data = $urandom();
        w1.dest = 5'd25;
        w1.data = $urandom();
        fork
            dma_send(0, w0, t0);
            dma_send(1, w1, t1);
        join
        if (t0 != t1) begin
            $display("the two channels were not accepted on the same cycle");
            test_errors++;
        end
        wait_drain();
        model[25] = (first_ch == 0) ? w0.data : w1.data;
        s.opcode = op_add3;
        s.addr_a = 5'd25;
        s.addr_b = ZERO_ADDR;
        s.addr_c = ZERO_ADDR;
        start_core(s);
        finish_core(res);
        if (res !== model[25]) begin
            $display("MISMATCH RESULT expected %08h got %08h", model[25], res);
            test_errors++;
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        dma0_valid = 1'b0;
        dma0_data = '0;
        dma1_valid = 1'b0;
        dma1_data = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        void'($urandom(32'h1502_7530));
        for (int i = 0; i < `FCORE_N_IO; i++) model[i] = '0;

        // Distinct dests per row, so the channel order inside a row is free
        set_entry(0, 5'd1, 5'd2, 5'd3, 5'd4, op_add3, 5'd1, 5'd3, 5'd4, 1'b0);
        set_entry(1, 5'd5, 5'd6, 5'd7, 5'd8, op_mac, 5'd5, 5'd7, 5'd8, 1'b0);
        set_entry(2, 5'd9, 5'd10, 5'd11, 5'd12, op_sub, 5'd9, 5'd11, 5'd12, 1'b0);
        set_entry(3, 5'd13, 5'd14, 5'd15, 5'd16, op_max3, 5'd13, 5'd15, 5'd16, 1'b0);
        set_entry(4, 5'd2, 5'd17, 5'd18, 5'd19, op_add3, 5'd2, 5'd17, 5'd18, 1'b1);
        set_entry(5, 5'd20, 5'd21, 5'd22, 5'd23, op_mac, 5'd21, 5'd23, 5'd20, 1'b1);

        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // Registers and memory come out of reset cleared
        apb_access(1'b0, `FCORE_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h0) begin
            $display("MISMATCH STATUS expected %08h got %08h", 32'h0, rdata);
            test_errors++;
        end
        apb_access(1'b0, `FCORE_REG_RESULT, '0, rdata, err);
        if (rdata !== 32'h0) begin
            $display("MISMATCH RESULT expected %08h got %08h", 32'h0, rdata);
            test_errors++;
        end
        sel = operand_sel_t'($urandom());
        sel.opcode = op_add3;
        start_core(sel);
        finish_core(got);
        if (got !== 32'h0) begin
            $display("MISMATCH RESULT expected %08h got %08h", 32'h0, got);
            test_errors++;
        end
        close_test("reset state");

        for (int t = 0; t < N_STIM; t++) begin
            entry = stim[t];
            for (int k = 0; k < 2; k++) begin
                words0[k].dest = entry.dest0[k];
                words0[k].data = $urandom();
                words1[k].dest = entry.dest1[k];
                words1[k].data = $urandom();
            end
            expected = expected_result(entry.sel);
            if (entry.inject) begin
                // Words sent during the run wait in the FIFOs until done
                start_core(entry.sel);
                fork
                    finish_core(got);
                    send_both(words0, words1);
                join
                if (got !== expected) begin
                    $display("MISMATCH RESULT expected %08h got %08h", expected, got);
                    test_errors++;
                end
            end else begin
                send_both(words0, words1);
            end
            wait_drain();
            for (int k = 0; k < 2; k++) begin
                model[words0[k].dest] = words0[k].data;
                model[words1[k].dest] = words1[k].data;
            end
            expected = expected_result(entry.sel);
            start_core(entry.sel);
            finish_core(got);
            if (got !== expected) begin
                $display("MISMATCH RESULT expected %08h got %08h", expected, got);
                test_errors++;
            end
            close_test($sformatf("stimulus row %0d opcode %0d", t, entry.sel.opcode));
        end

        check_round_robin(0);
        close_test("round robin, channel 0 writes last");
        check_round_robin(1);
        close_test("round robin, channel 1 writes last");

        // Busy is seen right after a start, done once it ends
        sel = stim[0].sel;
        start_core(sel);
        apb_access(1'b0, `FCORE_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h1) begin
            $display("MISMATCH STATUS expected %08h got %08h", 32'h1, rdata);
            test_errors++;
        end
        finish_core(got);
        apb_access(1'b0, `FCORE_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h2) begin
            $display("MISMATCH STATUS expected %08h got %08h", 32'h2, rdata);
            test_errors++;
        end
        // A second CTRL write lands in the busy window and must be dropped
        start_core(sel);
        apb_access(1'b1, `FCORE_REG_CTRL, 32'h1, rdata, err);
        apb_access(1'b0, `FCORE_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h2) begin
            $display("MISMATCH STATUS expected %08h got %08h", 32'h2, rdata);
            test_errors++;
        end
        apb_access(1'b0, `FCORE_REG_OPERAND, '0, rdata, err);
        if (rdata !== 32'(sel)) begin
            $display("MISMATCH OPERAND expected %08h got %08h", 32'(sel), rdata);
            test_errors++;
        end
        // A mapped offset must complete without an error response
        if (err !== 1'b0) begin
            $display("MISMATCH pslverr expected %h got %h", 1'b0, err);
            test_errors++;
        end
        apb_access(1'b0, 4'h2, '0, rdata, err);
        if (err !== 1'b1) begin
            $display("MISMATCH pslverr expected %h got %h", 1'b1, err);
            test_errors++;
        end
        close_test("status, restart while busy and pslverr");

        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== fcore_io_top.sv ====
`timescale 1ns/1ps

module fcore_io_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dma0_valid,
    input  fcore_io_pkg::io_write_t dma0_data,
    output logic                    dma0_ready,
    input  logic                    dma1_valid,
    input  fcore_io_pkg::io_write_t dma1_data,
    output logic                    dma1_ready,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [3:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import fcore_io_pkg::*;

    // Buffered channel streams into the arbiter
    logic [1:0]      buf_valid;
    io_write_t [1:0] buf_data;
    logic [1:0]      buf_ready;

    // Arbitrated stream into the memory
    logic      mem_valid;
    io_write_t mem_data;
    logic      mem_ready;

    io_addr_t     read_addr_a;
    io_addr_t     read_addr_b;
    io_addr_t     read_addr_c;
    logic [31:0]  read_data_a;
    logic [31:0]  read_data_b;
    logic [31:0]  read_data_c;
    logic         core_start;
    logic         core_done;
    logic         busy;
    logic [31:0]  result;
    logic         start_req;
    operand_sel_t operand_sel;

    io_stream_fifo fifo_0_i (
        .clock(clock), .reset(reset),
        .in_valid(dma0_valid), .in_data(dma0_data), .in_ready(dma0_ready),
        .out_valid(buf_valid[0]), .out_data(buf_data[0]), .out_ready(buf_ready[0])
    );

    io_stream_fifo fifo_1_i (
        .clock(clock), .reset(reset),
        .in_valid(dma1_valid), .in_data(dma1_data), .in_ready(dma1_ready),
        .out_valid(buf_valid[1]), .out_data(buf_data[1]), .out_ready(buf_ready[1])
    );

    io_write_arbiter arbiter_i (
        .clock(clock), .reset(reset),
        .req_valid(buf_valid), .req_data(buf_data), .req_ready(buf_ready),
        .out_valid(mem_valid), .out_data(mem_data), .out_ready(mem_ready)
    );

    common_io_memory memory_i (
        .clock(clock), .reset(reset),
        .core_start(core_start), .core_done(core_done),
        .wr_valid(mem_valid), .wr_data(mem_data), .wr_ready(mem_ready),
        .read_addr_a(read_addr_a), .read_addr_b(read_addr_b), .read_addr_c(read_addr_c),
        .read_data_a(read_data_a), .read_data_b(read_data_b), .read_data_c(read_data_c)
    );

    io_compute_core core_i (
        .clock(clock), .reset(reset),
        .start_req(start_req), .operand_sel(operand_sel),
        .read_addr_a(read_addr_a), .read_addr_b(read_addr_b), .read_addr_c(read_addr_c),
        .read_data_a(read_data_a), .read_data_b(read_data_b), .read_data_c(read_data_c),
        .core_start(core_start), .core_done(core_done), .busy(busy), .result(result)
    );

    apb_host_regs host_regs_i (
        .clock(clock), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start_req(start_req), .operand_sel(operand_sel),
        .busy(busy), .core_done(core_done), .result(result)
    );

endmodule

// ==== io_compute_core.sv ====
`timescale 1ns/1ps

module io_compute_core (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start_req,
    input  fcore_io_pkg::operand_sel_t   operand_sel,
    output fcore_io_pkg::io_addr_t       read_addr_a,
    output fcore_io_pkg::io_addr_t       read_addr_b,
    output fcore_io_pkg::io_addr_t       read_addr_c,
    input  logic [31:0]                  read_data_a,
    input  logic [31:0]                  read_data_b,
    input  logic [31:0]                  read_data_c,
    output logic                         core_start,
    output logic                         core_done,
    output logic                         busy,
    output logic [31:0]                  result
);
    import fcore_io_pkg::*;

    core_state_e  state;
    operand_sel_t sel_q;
    logic [31:0]  opnd_a;
    logic [31:0]  opnd_b;
    logic [31:0]  opnd_c;

    // One opcode applied to three words, results wrap at 32 bits
    function automatic logic [31:0] execute(input core_op_e op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] c);
        logic [31:0] max_ab;
        max_ab = (a > b) ? a : b;
        case (op)
            op_add3: execute = a + b + c;
            op_mac: execute = a * b + c;
            op_sub: execute = a - b - c;
            default: execute = (max_ab > c) ? max_ab : c;
        endcase
    endfunction

    // Addresses come straight from the latched selection
    assign read_addr_a = sel_q.addr_a;
    assign read_addr_b = sel_q.addr_b;
    assign read_addr_c = sel_q.addr_c;

    // Busy falls in the same cycle that done is pulsed
    assign busy = (state != core_idle);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= core_idle;
            core_start <= 1'b0;
            core_done <= 1'b0;
        end else begin
            core_start <= 1'b0;
            core_done <= 1'b0;
            case (state)
                core_idle: begin
                    if (start_req) begin
                        state <= core_fetch;
                        core_start <= 1'b1;
                    end
                end
                core_fetch: state <= core_exec;
                core_exec: state <= core_store;
                core_store: begin
                    state <= core_idle;
                    core_done <= 1'b1;
                end
                default: state <= core_idle;
            endcase
        end
    end

    // Selection at start, operands in exec, result in store
    always_ff @(posedge clock) begin
        if (state == core_idle && start_req) begin
            sel_q <= operand_sel;
        end
        if (state == core_exec) begin
            opnd_a <= read_data_a;
            opnd_b <= read_data_b;
            opnd_c <= read_data_c;
        end
        if (state == core_store) begin
            result <= execute(sel_q.opcode, opnd_a, opnd_b, opnd_c);
        end
    end

    assert property (@(posedge clock) disable iff (reset) core_done |=> !core_done);

endmodule

// ==== io_stream_fifo.sv ====
`timescale 1ns/1ps
`include "fcore_io_params.svh"

module io_stream_fifo (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_valid,
    input  fcore_io_pkg::io_write_t in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output fcore_io_pkg::io_write_t out_data,
    input  logic                    out_ready
);
    import fcore_io_pkg::*;

    localparam int DEPTH = `FCORE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    io_write_t        buffer [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             push;
    logic             pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // The oldest word is always presented at the output
    assign out_valid = (count != '0);
    assign out_data = buffer[rd_ptr];

    // Fill level after this cycle's push and pop
    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Ready is registered from the next fill level, so the source sees
    // back-pressure the cycle the last free entry is taken
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            in_ready <= 1'b0;
        end else begin
            count <= count_next;
            in_ready <= (count_next < (PTR_W + 1)'(DEPTH));
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            buffer[wr_ptr] <= in_data;
        end
    end

    // A push into a full buffer would overwrite the oldest held word
    assert property (@(posedge clock) disable iff (reset) push |-> count < DEPTH);

    // A pop from an empty buffer would hand stale data to the arbiter
    assert property (@(posedge clock) disable iff (reset) pop |-> count != '0);

endmodule

// ==== io_write_arbiter.sv ====
`timescale 1ns/1ps

module io_write_arbiter (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [1:0]                    req_valid,
    input  fcore_io_pkg::io_write_t [1:0] req_data,
    output logic [1:0]                    req_ready,
    output logic                          out_valid,
    output fcore_io_pkg::io_write_t       out_data,
    input  logic                          out_ready
);
    import fcore_io_pkg::*;

    // Channel that wins when both request at once
    logic prio;
    // Set while a granted word waits for the memory
    logic lock;
    logic grant_q;
    logic grant;

    // A held grant wins over everything, otherwise priority breaks a tie
    always_comb begin
        if (lock) begin
            grant = grant_q;
        end else if (req_valid[0] && req_valid[1]) begin
            grant = prio;
        end else begin
            grant = req_valid[1];
        end
    end

    assign out_valid = req_valid[grant];
    assign out_data = req_data[grant];

    // Only the granted channel sees the memory's ready
    always_comb begin
        req_ready = 2'b00;
        req_ready[grant] = out_ready && req_valid[grant];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            prio <= 1'b0;
            lock <= 1'b0;
            grant_q <= 1'b0;
        end else if (out_valid && out_ready) begin
            // Transfer done, so the other channel goes first next time
            lock <= 1'b0;
            prio <= ~grant;
        end else if (out_valid) begin
            lock <= 1'b1;
            grant_q <= grant;
        end
    end

    // A stalled word must stay put, which needs the FIFO and the lock together
    assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule
